// File: kbd_subsystem.f
+incdir+rtl
rtl/kbd_pkg.sv
rtl/ps2_frame_rx.sv
rtl/scan_translator.sv
rtl/scan_fifo.sv
rtl/kbd_port_regs.sv
rtl/kbd_subsystem.sv
test/kbd_subsystem_props.sv
test/kbd_subsystem_tb.sv

// File: rtl/kbd_config.svh
`ifndef KBD_CONFIG_SVH
`define KBD_CONFIG_SVH

// number of entries in the scan code queue.
// the translator starts with the same number of credits, so this is also the credit count.
// it has to be a power of two and at least 2, since the pointers wrap by overflow.
`define KBD_FIFO_DEPTH 8

`define KBD_DATA_PORT 16'h0060   // scan code data port read by the BIOS.
`define KBD_STATUS_PORT 16'h0064 // controller status port, bit 0 is output buffer full.

// flip-flops in front of each PS/2 line before any logic looks at it.
// two is the usual minimum for a 50 MHz clock against a slow keyboard clock.
// the receiver shifts the chain by one bit, so values below 2 do not build.
`define KBD_SYNC_STAGES 2

`endif

// File: rtl/kbd_pkg.sv
package kbd_pkg;

    // a single keyboard byte.
    // it holds a set 2 code on the PS/2 side and a set 1 code after translation.
    typedef logic [7:0] scan_code_t;

    // an x86 I/O port address, the full 16-bit space.
    typedef logic [15:0] port_addr_t;

    // the word that goes back to the CPU on an I/O read.
    // byte reads only look at the low half.
    typedef logic [15:0] port_word_t;

endpackage

// File: rtl/kbd_port_regs.sv
`include "kbd_config.svh"

module kbd_port_regs (
    input  logic                clock50,
    input  logic                arst_n,
    input  kbd_pkg::port_addr_t port_addr,
    input  logic                port_read,
    input  kbd_pkg::scan_code_t head_code,
    input  logic                not_empty,
    output logic                pop,
    output kbd_pkg::port_word_t port_in
);

    logic data_rd_q; // a read of port 60h was in progress last cycle.
    logic data_rd_end;

    // the address is latched with the strobe, so the CPU may move it as the read ends.
    assign data_rd_end = data_rd_q & ~port_read;

    // read data is purely combinational.
    always_comb begin
        case (port_addr)
            `KBD_DATA_PORT: begin
                port_in = not_empty ? {8'h00, head_code} : '0; // an empty queue reads zero.
            end
            `KBD_STATUS_PORT: begin
                // bit 0 tells the BIOS there is a byte waiting at 60h.
                port_in = {15'h0000, not_empty};
            end
            default: begin
                port_in = '0; // this block ignores every other port.
            end
        endcase
    end

    // the head is consumed only once the CPU has finished reading it.
    always_ff @(posedge clock50 or negedge arst_n) begin
        if (!arst_n) begin
            data_rd_q <= 1'b0;
            pop       <= 1'b0;
        end else begin
            data_rd_q <= port_read && (port_addr == `KBD_DATA_PORT);
            pop       <= data_rd_end && not_empty; // a read of an empty queue pops nothing.
        end
    end

endmodule

// File: rtl/kbd_subsystem.sv
`include "kbd_config.svh"

module kbd_subsystem (
    input  logic                clock50,
    input  logic                arst_n,
    input  logic                ps2_clk,
    input  logic                ps2_dat,
    input  kbd_pkg::port_addr_t port_addr,
    input  logic                port_read,
    output kbd_pkg::port_word_t port_in
);

    kbd_pkg::scan_code_t rx_code;   // checked set 2 byte from the line.
    logic                rx_valid;
    kbd_pkg::scan_code_t push_code; // translated set 1 code into the queue.
    logic                push;
    logic                credit_return;
    kbd_pkg::scan_code_t head_code;
    logic                not_empty;
    logic                pop;

    // deserializer, then translation, then the queue, then the CPU ports.
    ps2_frame_rx u_ps2_frame_rx (
        .clock50 (clock50),
        .arst_n  (arst_n),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .rx_code (rx_code),
        .rx_valid(rx_valid)
    );

    scan_translator u_scan_translator (
        .clock50      (clock50),
        .arst_n       (arst_n),
        .rx_code      (rx_code),
        .rx_valid     (rx_valid),
        .push         (push),
        .push_code    (push_code),
        .credit_return(credit_return)
    );

    scan_fifo #(
        .DEPTH(`KBD_FIFO_DEPTH) // must agree with the credits the translator starts with.
    ) u_scan_fifo (
        .clock50      (clock50),
        .arst_n       (arst_n),
        .push         (push),
        .push_code    (push_code),
        .pop          (pop),
        .head_code    (head_code),
        .not_empty    (not_empty),
        .credit_return(credit_return)
    );

    kbd_port_regs u_kbd_port_regs (
        .clock50  (clock50),
        .arst_n   (arst_n),
        .port_addr(port_addr),
        .port_read(port_read),
        .head_code(head_code),
        .not_empty(not_empty),
        .pop      (pop),
        .port_in  (port_in)
    );

endmodule

// File: rtl/ps2_frame_rx.sv
`include "kbd_config.svh"

module ps2_frame_rx (
    input  logic                clock50,
    input  logic                arst_n,
    input  logic                ps2_clk,
    input  logic                ps2_dat,
    output kbd_pkg::scan_code_t rx_code,
    output logic                rx_valid
);

    localparam int SYNC = `KBD_SYNC_STAGES;

    logic [SYNC-1:0] clk_sync; // the oldest sample sits in the top bit.
    logic [SYNC-1:0] dat_sync;
    logic            clk_prev; // synchronized clock one cycle back, for edge detection.
    logic            ps2_clk_s;
    logic            ps2_dat_s;
    logic            clk_fall;
    logic [10:0]     frame_sr; // start, eight data bits, parity, stop.
    logic [3:0]      bit_cnt;
    logic [7:0]      idle_cnt; // cycles the PS/2 clock has stayed high.
    logic            frame_ok;

    assign ps2_clk_s = clk_sync[SYNC-1];
    assign ps2_dat_s = dat_sync[SYNC-1];
    assign clk_fall  = clk_prev & ~ps2_clk_s; // the keyboard changes data on the rising edge.

    // start low, stop high, and odd parity over the data bits plus the parity bit.
    assign frame_ok = ~frame_sr[0] & frame_sr[10] & (^frame_sr[9:1]);

    always_ff @(posedge clock50 or negedge arst_n) begin
        if (!arst_n) begin
            clk_sync <= '1; // both lines idle high.
            dat_sync <= '1;
            clk_prev <= 1'b1;
            bit_cnt  <= '0;
            idle_cnt <= '0;
            rx_valid <= 1'b0;
        end else begin
            clk_sync <= {clk_sync[SYNC-2:0], ps2_clk};
            dat_sync <= {dat_sync[SYNC-2:0], ps2_dat};
            clk_prev <= ps2_clk_s;
            rx_valid <= 1'b0;
            // count idle cycles and hold at the top value.
            if (!ps2_clk_s) begin
                idle_cnt <= '0;
            end else if (idle_cnt != 8'hFF) begin
                idle_cnt <= idle_cnt + 8'd1;
            end
            if (bit_cnt == 4'd11) begin
                bit_cnt  <= '0;       // a full frame is in, check it this cycle.
                rx_valid <= frame_ok; // a bad frame is simply dropped.
            end else if (clk_fall) begin
                // the start bit after a long idle still sees the idle count at its top value.
                bit_cnt <= bit_cnt + 4'd1;
            end else if (idle_cnt == 8'hFF) begin
                bit_cnt <= '0; // a truncated frame is abandoned after a long idle.
            end
        end
    end

    // payload path. bits come LSB first, so new bits enter at the top.
    always_ff @(posedge clock50) begin
        if (clk_fall) begin
            frame_sr <= {ps2_dat_s, frame_sr[10:1]};
        end
        if (bit_cnt == 4'd11) begin
            rx_code <= frame_sr[8:1];
        end
    end

endmodule

// File: rtl/scan_fifo.sv
`include "kbd_config.svh"

module scan_fifo #(
    parameter int DEPTH = `KBD_FIFO_DEPTH
) (
    input  logic                clock50,
    input  logic                arst_n,
    input  logic                push,
    input  kbd_pkg::scan_code_t push_code,
    input  logic                pop,
    output kbd_pkg::scan_code_t head_code,
    output logic                not_empty,
    output logic                credit_return
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    kbd_pkg::scan_code_t mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr; // both pointers wrap on their own since DEPTH is 2**PTR_W.
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;

    // the head is read straight out of the array, so a pop shows up one cycle later.
    assign head_code = mem[rd_ptr];
    assign not_empty = (count != '0);

    // no full check here, the sender never pushes without a credit.
    always_ff @(posedge clock50) begin
        if (push) begin
            mem[wr_ptr] <= push_code;
        end
    end

    always_ff @(posedge clock50 or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop; // each freed entry goes back as one credit.
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            if (push && !pop) begin
                count <= count + CNT_W'(1);
            end else if (pop && !push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

endmodule

// File: rtl/scan_translator.sv
`include "kbd_config.svh"

module scan_translator (
    input  logic                clock50,
    input  logic                arst_n,
    input  kbd_pkg::scan_code_t rx_code,
    input  logic                rx_valid,
    output logic                push,
    output kbd_pkg::scan_code_t push_code,
    input  logic                credit_return
);

    localparam kbd_pkg::scan_code_t BREAK_PREFIX = 8'hF0; // set 2 key release prefix.
    localparam int CREDIT_W = $clog2(`KBD_FIFO_DEPTH + 1);

    kbd_pkg::scan_code_t xt_code;
    logic                break_flag; // the last accepted byte was F0.
    logic [CREDIT_W-1:0] credit_cnt; // free queue entries as seen from here.
    logic                is_break;
    logic                has_credit;
    logic                push_fire;

    assign is_break   = (rx_code == BREAK_PREFIX);
    assign has_credit = (credit_cnt != '0);
    // a code with no free entry behind it is thrown away here.
    assign push_fire  = rx_valid & ~is_break & has_credit;

    // set 2 to set 1 lookup. anything not listed, E0 and E1 included, goes through as is.
    always_comb begin
        case (rx_code)
            8'h1C: xt_code = 8'h1E; // letters a to z follow.
            8'h32: xt_code = 8'h30;
            8'h21: xt_code = 8'h2E;
            8'h23: xt_code = 8'h20;
            8'h24: xt_code = 8'h12;
            8'h2B: xt_code = 8'h21;
            8'h34: xt_code = 8'h22;
            8'h33: xt_code = 8'h23;
            8'h43: xt_code = 8'h17;
            8'h3B: xt_code = 8'h24;
            8'h42: xt_code = 8'h25;
            8'h4B: xt_code = 8'h26;
            8'h3A: xt_code = 8'h32;
            8'h31: xt_code = 8'h31;
            8'h44: xt_code = 8'h18;
            8'h4D: xt_code = 8'h19;
            8'h15: xt_code = 8'h10;
            8'h2D: xt_code = 8'h13;
            8'h1B: xt_code = 8'h1F;
            8'h2C: xt_code = 8'h14;
            8'h3C: xt_code = 8'h16;
            8'h2A: xt_code = 8'h2F;
            8'h1D: xt_code = 8'h11;
            8'h22: xt_code = 8'h2D;
            8'h35: xt_code = 8'h15;
            8'h1A: xt_code = 8'h2C;
            8'h45: xt_code = 8'h0B; // digit row, 0 first and then 1 to 9.
            8'h16: xt_code = 8'h02;
            8'h1E: xt_code = 8'h03;
            8'h26: xt_code = 8'h04;
            8'h25: xt_code = 8'h05;
            8'h2E: xt_code = 8'h06;
            8'h36: xt_code = 8'h07;
            8'h3D: xt_code = 8'h08;
            8'h3E: xt_code = 8'h09;
            8'h46: xt_code = 8'h0A;
            8'h0E: xt_code = 8'h29; // backquote and tilde.
            8'h4E: xt_code = 8'h0C;
            8'h55: xt_code = 8'h0D;
            8'h5D: xt_code = 8'h2B; // backslash.
            8'h54: xt_code = 8'h1A;
            8'h5B: xt_code = 8'h1B;
            8'h4C: xt_code = 8'h27;
            8'h52: xt_code = 8'h28;
            8'h41: xt_code = 8'h33;
            8'h49: xt_code = 8'h34;
            8'h4A: xt_code = 8'h35;
            8'h66: xt_code = 8'h0E; // backspace.
            8'h29: xt_code = 8'h39; // space bar.
            8'h0D: xt_code = 8'h0F; // tab.
            8'h58: xt_code = 8'h3A; // caps lock.
            8'h12: xt_code = 8'h2A; // left shift.
            8'h14: xt_code = 8'h1D; // left ctrl.
            8'h11: xt_code = 8'h38; // left alt.
            8'h1F: xt_code = 8'h5B; // left windows key.
            8'h59: xt_code = 8'h36; // right shift.
            8'h27: xt_code = 8'h5C; // right windows key.
            8'h2F: xt_code = 8'h5D; // menu key.
            8'h5A: xt_code = 8'h1C; // enter.
            8'h76: xt_code = 8'h01; // escape.
            8'h05: xt_code = 8'h3B; // function keys F1 to F12 follow.
            8'h06: xt_code = 8'h3C;
            8'h04: xt_code = 8'h3D;
            8'h0C: xt_code = 8'h3E;
            8'h03: xt_code = 8'h3F;
            8'h0B: xt_code = 8'h40;
            8'h83: xt_code = 8'h41; // F7 is the one set 2 code above 7F.
            8'h0A: xt_code = 8'h42;
            8'h01: xt_code = 8'h43;
            8'h09: xt_code = 8'h44;
            8'h78: xt_code = 8'h57;
            8'h07: xt_code = 8'h58;
            8'h7E: xt_code = 8'h46; // scroll lock.
            8'h77: xt_code = 8'h45; // num lock.
            8'h7C: xt_code = 8'h37; // keypad star.
            8'h7B: xt_code = 8'h4A; // keypad minus.
            8'h79: xt_code = 8'h4E; // keypad plus.
            8'h71: xt_code = 8'h53; // keypad dot.
            8'h70: xt_code = 8'h52; // keypad digits 0 to 9 follow.
            8'h69: xt_code = 8'h4F;
            8'h72: xt_code = 8'h50;
            8'h7A: xt_code = 8'h51;
            8'h6B: xt_code = 8'h4B;
            8'h73: xt_code = 8'h4C;
            8'h74: xt_code = 8'h4D;
            8'h6C: xt_code = 8'h47;
            8'h75: xt_code = 8'h48;
            8'h7D: xt_code = 8'h49;
            default: xt_code = rx_code;
        endcase
    end

    always_ff @(posedge clock50 or negedge arst_n) begin
        if (!arst_n) begin
            push       <= 1'b0;
            break_flag <= 1'b0;
            credit_cnt <= CREDIT_W'(`KBD_FIFO_DEPTH); // the queue starts empty.
        end else begin
            push <= push_fire;
            if (rx_valid) begin
                break_flag <= is_break; // any other byte consumes a pending release.
            end
            // a spent and a returned credit in one cycle cancel out.
            if (push_fire && !credit_return) begin
                credit_cnt <= credit_cnt - CREDIT_W'(1);
            end else if (credit_return && !push_fire) begin
                credit_cnt <= credit_cnt + CREDIT_W'(1);
            end
        end
    end

    // a release in set 1 is the make code with bit 7 set.
    always_ff @(posedge clock50) begin
        if (push_fire) begin
            push_code <= break_flag ? {1'b1, xt_code[6:0]} : xt_code;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the keyboard testbench with Verilator, runs it and judges the run by its log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f kbd_subsystem.f \
    --top-module kbd_subsystem_tb -o kbd_sim &&
    ./obj_dir/kbd_sim | tee sim.log ||
    { echo "build or simulation step failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

// File: test/kbd_subsystem_props.sv
`include "kbd_config.svh"

module kbd_subsystem_props (
    input logic                                   clock50,
    input logic                                   arst_n,
    input logic                                   push,
    input logic                                   pop,
    input logic                                   not_empty,
    input logic                                   credit_return,
    input logic [$clog2(`KBD_FIFO_DEPTH + 1)-1:0] credit_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CW = $clog2(`KBD_FIFO_DEPTH + 1);
    localparam logic [CW-1:0] MAX_CREDITS = CW'(`KBD_FIFO_DEPTH); // one credit per queue entry.

    // the translator can never hold more credits than the queue has entries.
    credit_range: assert property (@(posedge clock50) disable iff (!arst_n)
        credit_cnt <= MAX_CREDITS)
        else $error("credit count %0d is above the queue depth", credit_cnt);

    // push is registered, so the credit it spent shows in the count one cycle back.
    push_has_credit: assert property (@(posedge clock50) disable iff (!arst_n)
        push |-> $past(credit_cnt) != '0)
        else $error("push was issued while the translator held no credit");

    pop_not_empty: assert property (@(posedge clock50) disable iff (!arst_n)
        pop |-> not_empty)
        else $error("pop was issued while the queue was empty");

    // every pop is answered by exactly one credit, one cycle later.
    pop_returns_credit: assert property (@(posedge clock50) disable iff (!arst_n)
        pop |=> credit_return)
        else $error("a pop was not followed by credit_return");
    credit_after_pop: assert property (@(posedge clock50) disable iff (!arst_n)
        credit_return |-> $past(pop))
        else $error("credit_return came without a pop one cycle before");

endmodule

bind kbd_subsystem kbd_subsystem_props u_kbd_subsystem_props (
    .clock50      (clock50),
    .arst_n       (arst_n),
    .push         (push),
    .pop          (pop),
    .not_empty    (not_empty),
    .credit_return(credit_return),
    .credit_cnt   (u_scan_translator.credit_cnt)
);

// File: test/kbd_subsystem_tb.sv
`include "kbd_config.svh"

module kbd_subsystem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // one row: up to two AT bytes, a parity fault, and the XT code expected at port 60h.
    typedef struct packed {
        logic [1:0]          n_bytes;
        kbd_pkg::scan_code_t b0;
        kbd_pkg::scan_code_t b1;
        logic                bad_parity;
        logic                has_code;
        kbd_pkg::scan_code_t xt;
    } stim_t;

    localparam int N_STIM = 16;
    localparam stim_t STIM [N_STIM] = '{
        '{2'd1, 8'h1C, 8'h00, 1'b0, 1'b1, 8'h1E}, // letter a.
        '{2'd1, 8'h32, 8'h00, 1'b0, 1'b1, 8'h30}, // letter b.
        '{2'd1, 8'h45, 8'h00, 1'b0, 1'b1, 8'h0B}, // digit 0.
        '{2'd1, 8'h29, 8'h00, 1'b0, 1'b1, 8'h39}, // space bar.
        '{2'd1, 8'h5A, 8'h00, 1'b0, 1'b1, 8'h1C}, // enter.
        '{2'd1, 8'h76, 8'h00, 1'b0, 1'b1, 8'h01}, // escape.
        '{2'd1, 8'h05, 8'h00, 1'b0, 1'b1, 8'h3B}, // F1.
        '{2'd1, 8'h83, 8'h00, 1'b0, 1'b1, 8'h41}, // F7, the odd one above 7Fh.
        '{2'd1, 8'h70, 8'h00, 1'b0, 1'b1, 8'h52}, // keypad 0.
        '{2'd2, 8'hF0, 8'h1C, 1'b0, 1'b1, 8'h9E}, // release of a.
        '{2'd1, 8'h1C, 8'h00, 1'b0, 1'b1, 8'h1E}, // the next make has bit 7 clear again.
        '{2'd2, 8'hF0, 8'h12, 1'b0, 1'b1, 8'hAA}, // release of left shift.
        '{2'd1, 8'hE0, 8'h00, 1'b0, 1'b1, 8'hE0}, // extended prefix goes through.
        '{2'd1, 8'h99, 8'h00, 1'b0, 1'b1, 8'h99}, // unmapped code goes through.
        '{2'd1, 8'h24, 8'h00, 1'b1, 1'b0, 8'h00}, // parity fault, nothing queued.
        '{2'd1, 8'h24, 8'h00, 1'b0, 1'b1, 8'h12}  // same key, sent cleanly.
    };

    // three more frames than the queue holds. only the first eight survive.
    localparam kbd_pkg::scan_code_t OVF_AT [`KBD_FIFO_DEPTH + 3] = '{
        8'h15, 8'h1D, 8'h24, 8'h2D, 8'h2C, 8'h35, 8'h3C, 8'h43, 8'h44, 8'h4D, 8'h1C
    };
    localparam kbd_pkg::scan_code_t OVF_XT [`KBD_FIFO_DEPTH] = '{
        8'h10, 8'h11, 8'h12, 8'h13, 8'h14, 8'h15, 8'h16, 8'h17
    };

    logic                clock50;
    logic                arst_n;
    logic                ps2_clk;
    logic                ps2_dat;
    logic                port_read;
    kbd_pkg::port_addr_t port_addr;
    kbd_pkg::port_word_t port_in;
    int                  check_errors;
    int                  tests_run;
    int                  tests_failed;
    int                  cycle_count;
    int                  cycle_limit;
    int                  total_bytes;

    kbd_subsystem u_kbd_subsystem (
        .clock50  (clock50),
        .arst_n   (arst_n),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .port_addr(port_addr),
        .port_read(port_read),
        .port_in  (port_in)
    );

    always #50 clock50 = ~clock50; // 100 ns period.

    // watchdog. the limit is set from the number of frames before the clock starts.
    always @(posedge clock50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run went past its limit of %0d clock cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // sends one PS/2 frame LSB first, four clocks per half bit, then idles a random gap.
    task automatic send_frame(input kbd_pkg::scan_code_t code, input logic bad_parity);
        logic [10:0] frame;
        int unsigned gap;
        frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0}; // stop, parity, data, start.
        @(posedge clock50);
        for (int b = 0; b < 11; b++) begin
            ps2_dat <= frame[b]; // data moves while the line clock is high.
            repeat (4) @(posedge clock50);
            ps2_clk <= 1'b0;     // the receiver samples on this falling edge.
            repeat (4) @(posedge clock50);
            ps2_clk <= 1'b1;
        end
        gap = 2 + ($urandom % 8);
        repeat (gap) @(posedge clock50);
    endtask

    // a CPU read cycle of two clocks, sampled in the middle of the second one.
    task automatic read_port(input kbd_pkg::port_addr_t addr, output kbd_pkg::port_word_t data);
        @(posedge clock50);
        port_addr <= addr;
        port_read <= 1'b1;
        @(posedge clock50);
        @(negedge clock50);
        data = port_in;
        @(posedge clock50);
        port_read <= 1'b0;
        port_addr <= '0;
        repeat (2) @(posedge clock50); // lets a pop settle before the next access.
    endtask

    task automatic read_and_check(input kbd_pkg::port_addr_t addr,
                                  input kbd_pkg::port_word_t expected);
        kbd_pkg::port_word_t data;
        read_port(addr, data);
        assert (data === expected)
        else begin
            $display("Mismatch at %0t ns: port_in at port %h expected %h, got %h",
                     $time, addr, expected, data);
            check_errors++;
        end
    endtask

    // polls the status port until bit 0 says a code is waiting.
    task automatic wait_ready();
        kbd_pkg::port_word_t status;
        int polls;
        polls = 0;
        status = '0;
        while (status[0] !== 1'b1 && polls < 40) begin
            read_port(`KBD_STATUS_PORT, status);
            polls++;
        end
        assert (status[0] === 1'b1)
        else begin
            $display("no scan code became ready on port 64h after %0d status reads", polls);
            check_errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (check_errors != errs_before) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    initial begin
        int errs;
        void'($urandom(23));
        clock50 = 1'b0;
        arst_n = 1'b0;
        ps2_clk = 1'b1; // both PS/2 lines idle high.
        ps2_dat = 1'b1;
        port_addr = '0;
        port_read = 1'b0;
        check_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycle_count = 0;
        total_bytes = `KBD_FIFO_DEPTH + 4; // overflow frames plus the decode frame.
        foreach (STIM[i]) begin
            total_bytes += int'(STIM[i].n_bytes);
        end
        cycle_limit = (total_bytes + 10) * 100;
        repeat (3) @(posedge clock50);
        arst_n <= 1'b1;

        for (int i = 0; i < N_STIM; i++) begin
            errs = check_errors;
            send_frame(STIM[i].b0, STIM[i].bad_parity);
            if (STIM[i].n_bytes == 2'd2) begin
                send_frame(STIM[i].b1, STIM[i].bad_parity);
            end
            if (STIM[i].has_code) begin
                wait_ready();
                read_and_check(`KBD_DATA_PORT, {8'h00, STIM[i].xt});
            end else begin
                repeat (8) @(posedge clock50); // longer than the receive latency.
            end
            read_and_check(`KBD_STATUS_PORT, 16'h0000); // nothing is left behind.
            finish_test($sformatf("table row %0d", i), errs);
        end

        errs = check_errors;
        send_frame(8'h29, 1'b0);
        wait_ready();
        read_and_check(`KBD_STATUS_PORT, 16'h0001);
        read_and_check(16'h0061, 16'h0000); // a neighbouring port decodes to nothing.
        read_and_check(`KBD_DATA_PORT, 16'h0039);
        read_and_check(`KBD_DATA_PORT, 16'h0000); // the queue is empty now.
        read_and_check(`KBD_STATUS_PORT, 16'h0000);
        finish_test("port decode", errs);

        errs = check_errors;
        for (int i = 0; i < `KBD_FIFO_DEPTH + 3; i++) begin
            send_frame(OVF_AT[i], 1'b0);
        end
        repeat (8) @(posedge clock50);
        for (int i = 0; i < `KBD_FIFO_DEPTH; i++) begin
            read_and_check(`KBD_DATA_PORT, {8'h00, OVF_XT[i]});
        end
        read_and_check(`KBD_STATUS_PORT, 16'h0000); // the extra frames were dropped.
        finish_test("queue overflow", errs);

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && check_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
